// ==== Makefile ====
# Verilator build and run for the stride prefetcher testbench

TOP = tb_pref_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f flist.f --top-module $(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "^SIMULATION PASSED$$"

clean:
	rm -rf obj_dir

// ==== flist.f ====
pref_cfg_pkg.sv
pref_entry_pkg.sv
pref_train_if.sv
pref_load_monitor.sv
pref_stride_table.sv
pref_ring_fifo.sv
pref_stream_gen.sv
pref_recent_filter.sv
pref_top.sv
tb_pref_top.sv

// ==== pref_cfg_pkg.sv ====
// stride prefetcher address geometry, table sizes and word types
package pref_cfg_pkg;

  // ----------------------------------------
  // address geometry
  // ----------------------------------------
  localparam int VADDR_W    = 32;  // data and instruction addresses
  localparam int LINE_W     = 6;   // 64 byte lines
  localparam int PAGE_OFS_W = 12;  // 4 KiB page offset

  // ----------------------------------------
  // table and queue sizes
  // ----------------------------------------
  localparam int IPT_SIZE    = 16;  // indexed by pc[4:1]
  localparam int IPT_IDX_W   = $clog2(IPT_SIZE);
  localparam int PC_TAG_W    = 9;   // pc bits kept above the index
  localparam int NUM_DEGREE  = 4;   // prefetches per stream request
  localparam int FILTER_SIZE = 16;  // recent line slots
  localparam int REQ_DEPTH   = 4;
  localparam int ISSUE_DEPTH = 8;

  typedef logic [VADDR_W-1:0]             vaddr_t;
  typedef logic [VADDR_W-LINE_W-1:0]      line_t;    // address without line offset
  typedef logic [$clog2(NUM_DEGREE)-1:0]  degree_t;  // addresses done in a stream
  typedef logic [$clog2(FILTER_SIZE)-1:0] slot_t;    // recent filter slot number

endpackage

// ==== pref_entry_pkg.sv ====
// stride table entry, stream request and generator state types
package pref_entry_pkg;

  typedef logic [pref_cfg_pkg::IPT_IDX_W-1:0] ipt_idx_t;
  typedef logic [pref_cfg_pkg::PC_TAG_W-1:0]  pc_tag_t;

  // difference of two page offsets, wraps inside the page
  typedef logic signed [pref_cfg_pkg::PAGE_OFS_W-1:0] stride_t;

  typedef logic [1:0] conf_t;  // saturating, 3 is max

  // ----------------------------------------
  // one stride table entry per load pc
  // ----------------------------------------
  typedef struct packed {
    logic                                valid;
    pc_tag_t                             tag;
    logic [pref_cfg_pkg::PAGE_OFS_W-1:0] last_ofs;  // page offset of last load
    stride_t                             stride;
    conf_t                               conf;
  } ipt_entry_t;

  // confirmed stream waiting for the generator
  typedef struct packed {
    pref_cfg_pkg::vaddr_t base;  // address of the confirming load
    stride_t              stride;
  } stream_req_t;

  typedef enum logic {
    GEN_IDLE = 1'b0,  // waiting for a request
    GEN_RUN  = 1'b1   // expanding addresses
  } gen_state_t;

endpackage

// ==== pref_load_monitor.sv ====
// load monitor, registers load reports and drops repeated line touches
module pref_load_monitor (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  logic                 i_ld_valid,
  input  pref_cfg_pkg::vaddr_t i_ld_pc,
  input  pref_cfg_pkg::vaddr_t i_ld_vaddr,
  pref_train_if.mon            train
);
  import pref_cfg_pkg::*;

  logic   r_ld_valid;
  vaddr_t r_ld_pc;
  vaddr_t r_ld_vaddr;
  logic   r_last_valid;  // something accepted since reset
  vaddr_t r_last_pc;
  line_t  r_last_line;
  line_t  w_line;
  logic   w_repeat;
  logic   w_accept;

  // ----------------------------------------
  // stage 1, capture the load report
  // ----------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ld_valid <= 1'b0;
    end else begin
      r_ld_valid <= i_ld_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ld_pc    <= i_ld_pc;
    r_ld_vaddr <= i_ld_vaddr;
  end

  // ----------------------------------------
  // stage 2, repeat check and training strobe
  // ----------------------------------------
  assign w_line   = r_ld_vaddr[VADDR_W-1:LINE_W];
  assign w_repeat = r_last_valid && (r_last_pc == r_ld_pc) && (r_last_line == w_line);
  assign w_accept = r_ld_valid && !w_repeat;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      train.valid  <= 1'b0;
      r_last_valid <= 1'b0;
    end else begin
      train.valid <= w_accept;
      if (w_accept) r_last_valid <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_accept) begin
      r_last_pc   <= r_ld_pc;
      r_last_line <= w_line;
      train.idx   <= r_ld_pc[1 +: IPT_IDX_W];          // bit 0 never used by pc
      train.tag   <= r_ld_pc[IPT_IDX_W+1 +: PC_TAG_W];
      train.vaddr <= r_ld_vaddr;
    end
  end

  // back to back strobes always carry a new instruction or line
  a_no_repeat: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    train.valid && $past(train.valid) |->
      {train.tag, train.idx, train.vaddr[VADDR_W-1:LINE_W]} !=
      $past({train.tag, train.idx, train.vaddr[VADDR_W-1:LINE_W]}));

endmodule

// ==== pref_recent_filter.sv ====
// recent line filter with round-robin slots, in front of the issue FIFO
module pref_recent_filter (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  logic                 i_gen_valid,
  input  pref_cfg_pkg::vaddr_t i_gen_vaddr,
  output logic                 o_accept,
  input  logic                 i_pref_ready,
  output logic                 o_pref_valid,
  output pref_cfg_pkg::vaddr_t o_pref_vaddr
);
  import pref_cfg_pkg::*;

  line_t            r_lines [FILTER_SIZE];
  logic [FILTER_SIZE-1:0] r_slot_valid;
  slot_t            r_rr_ptr;      // next slot to overwrite
  line_t            w_line;
  logic [FILTER_SIZE-1:0] w_hit;
  logic             w_push;
  logic             w_pop;
  logic             w_full;
  logic             w_empty;
  vaddr_t           w_issue_vaddr;

  assign w_line = i_gen_vaddr[VADDR_W-1:LINE_W];

  always_comb begin
    for (int i = 0; i < FILTER_SIZE; i++) begin
      w_hit[i] = r_slot_valid[i] && (r_lines[i] == w_line);
    end
  end

  assign o_accept = !w_full;
  assign w_push   = i_gen_valid && o_accept && !(|w_hit);  // hit is dropped

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_slot_valid <= '0;
      r_rr_ptr     <= '0;
    end else if (w_push) begin
      r_slot_valid[r_rr_ptr] <= 1'b1;
      r_rr_ptr               <= r_rr_ptr + 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_push) r_lines[r_rr_ptr] <= w_line;
  end

  // ----------------------------------------
  // issue FIFO, drained by the cache pipe
  // ----------------------------------------
  pref_ring_fifo #(
    .DEPTH (ISSUE_DEPTH),
    .T     (vaddr_t)
  ) u_issue_fifo (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_push    (w_push),
    .i_data    (i_gen_vaddr),
    .i_pop     (w_pop),
    .o_data    (w_issue_vaddr),
    .o_empty   (w_empty),
    .o_full    (w_full)
  );

  assign w_pop        = i_pref_ready && !w_empty;
  assign o_pref_valid = w_pop;          // popped in the same cycle
  assign o_pref_vaddr = w_issue_vaddr;

endmodule

// ==== pref_ring_fifo.sv ====
// ring buffer FIFO, depth and element type set by parameters
module pref_ring_fifo #(
  parameter int  DEPTH = 4,
  parameter type T     = logic [31:0]
) (
  input  logic i_clk,
  input  logic i_reset_n,
  input  logic i_push,
  input  T     i_data,
  input  logic i_pop,
  output T     o_data,
  output logic o_empty,
  output logic o_full
);

  typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

  T     r_mem [DEPTH];
  ptr_t r_wr_ptr;
  ptr_t r_rd_ptr;
  cnt_t r_count;
  logic w_wr;
  logic w_rd;

  assign o_empty = (r_count == '0);
  assign o_full  = (r_count == cnt_t'(DEPTH));
  assign o_data  = r_mem[r_rd_ptr];  // oldest entry
  assign w_wr    = i_push && !o_full;
  assign w_rd    = i_pop && !o_empty;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_count  <= '0;
    end else begin
      if (w_wr) r_wr_ptr <= (r_wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : r_wr_ptr + 1'b1;
      if (w_rd) r_rd_ptr <= (r_rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : r_rd_ptr + 1'b1;
      if (w_wr && !w_rd) r_count <= r_count + 1'b1;
      else if (w_rd && !w_wr) r_count <= r_count - 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_wr) r_mem[r_wr_ptr] <= i_data;
  end

  a_no_pop_empty: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_pop |-> !o_empty);
  a_no_push_full: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_push |-> !o_full);

endmodule

// ==== pref_stream_gen.sv ====
// stream generator, expands one stream request into NUM_DEGREE addresses
module pref_stream_gen (
  input  logic                        i_clk,
  input  logic                        i_reset_n,
  input  logic                        i_req_empty,
  input  pref_entry_pkg::stream_req_t i_req,
  output logic                        o_req_pop,
  output logic                        o_gen_valid,
  output pref_cfg_pkg::vaddr_t        o_gen_vaddr,
  input  logic                        i_accept
);
  import pref_cfg_pkg::*;
  import pref_entry_pkg::*;

  gen_state_t r_state;
  degree_t    r_degree;
  vaddr_t     r_vaddr;
  vaddr_t     r_stride;      // sign extended
  vaddr_t     w_req_stride;

  assign w_req_stride = vaddr_t'($signed(i_req.stride));
  assign o_req_pop    = (r_state == GEN_IDLE) && !i_req_empty;
  assign o_gen_valid  = (r_state == GEN_RUN);
  assign o_gen_vaddr  = r_vaddr;

  // ----------------------------------------
  // FSM and degree count
  // ----------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state  <= GEN_IDLE;
      r_degree <= '0;
    end else begin
      case (r_state)
        GEN_IDLE: begin
          if (o_req_pop) begin
            r_state  <= GEN_RUN;
            r_degree <= '0;
          end
        end
        GEN_RUN: begin
          if (i_accept) begin  // held while the issue FIFO is full
            if (r_degree == degree_t'(NUM_DEGREE - 1)) r_state <= GEN_IDLE;
            else r_degree <= r_degree + 1'b1;
          end
        end
        default: r_state <= GEN_IDLE;
      endcase
    end
  end

  // first address is one stride past the load
  always_ff @(posedge i_clk) begin
    if (o_req_pop) begin
      r_vaddr  <= i_req.base + w_req_stride;
      r_stride <= w_req_stride;
    end else if (o_gen_valid && i_accept) begin
      r_vaddr <= r_vaddr + r_stride;
    end
  end

endmodule

// ==== pref_stride_table.sv ====
// stride table, learns stride and confidence per load pc and emits streams
module pref_stride_table (
  input  logic                        i_clk,
  input  logic                        i_reset_n,
  pref_train_if.tbl                   train,
  input  logic                        i_req_full,
  output logic                        o_req_push,
  output pref_entry_pkg::stream_req_t o_req
);
  import pref_cfg_pkg::*;
  import pref_entry_pkg::*;

  ipt_entry_t            r_entries [IPT_SIZE];
  ipt_entry_t            w_entry;   // entry selected by the training pc
  logic [PAGE_OFS_W-1:0] w_ofs;
  stride_t               w_stride;
  logic                  w_hit;
  logic                  w_match;   // same stride as last time

  function automatic conf_t inc_conf(conf_t c);
    return (c == 2'd3) ? c : c + 2'd1;
  endfunction

  function automatic conf_t dec_conf(conf_t c);
    return (c == 2'd0) ? c : c - 2'd1;
  endfunction

  // ----------------------------------------
  // lookup
  // ----------------------------------------
  assign w_entry  = r_entries[train.idx];
  assign w_ofs    = train.vaddr[PAGE_OFS_W-1:0];
  assign w_stride = w_ofs - w_entry.last_ofs;  // wraps inside the page
  assign w_hit    = w_entry.valid && (w_entry.tag == train.tag);
  assign w_match  = (w_stride == w_entry.stride);

  // confirmed only with two matching strides already seen
  assign o_req_push = train.valid && w_hit && w_match && (w_entry.conf >= 2'd2) &&
                      (w_stride != '0) && !i_req_full;
  assign o_req.base   = train.vaddr;
  assign o_req.stride = w_stride;

  // ----------------------------------------
  // update
  // ----------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < IPT_SIZE; i++) begin
        r_entries[i] <= '0;
      end
    end else if (train.valid) begin
      if (w_hit) begin
        r_entries[train.idx].last_ofs <= w_ofs;
        r_entries[train.idx].stride   <= w_stride;
        r_entries[train.idx].conf     <= w_match ? inc_conf(w_entry.conf)
                                                 : dec_conf(w_entry.conf);
      end else begin
        // new pc or another pc on the same index, start over
        r_entries[train.idx] <= '{valid:    1'b1,
                                  tag:      train.tag,
                                  last_ofs: w_ofs,
                                  stride:   '0,
                                  conf:     '0};
      end
    end
  end

  // a confirmed stream leaves its entry saturated with the pushed stride
  a_push_saturates: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_req_push |=> (r_entries[$past(train.idx)].conf == 2'd3) &&
                   (r_entries[$past(train.idx)].stride == $past(o_req.stride)));

endmodule

// ==== pref_top.sv ====
// stride prefetcher top, load monitor through to the prefetch issue port
module pref_top (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  logic                 i_ld_valid,
  input  pref_cfg_pkg::vaddr_t i_ld_pc,
  input  pref_cfg_pkg::vaddr_t i_ld_vaddr,
  input  logic                 i_pref_ready,
  output logic                 o_pref_valid,
  output pref_cfg_pkg::vaddr_t o_pref_vaddr
);
  import pref_cfg_pkg::*;
  import pref_entry_pkg::*;

  logic        w_req_push;
  stream_req_t w_req_in;
  logic        w_req_pop;
  stream_req_t w_req_out;
  logic        w_req_empty;
  logic        w_req_full;
  logic        w_gen_valid;
  vaddr_t      w_gen_vaddr;
  logic        w_accept;

  pref_train_if u_train_if ();

  pref_load_monitor u_monitor (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_ld_valid (i_ld_valid),
    .i_ld_pc    (i_ld_pc),
    .i_ld_vaddr (i_ld_vaddr),
    .train      (u_train_if.mon)
  );

  pref_stride_table u_table (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .train      (u_train_if.tbl),
    .i_req_full (w_req_full),
    .o_req_push (w_req_push),
    .o_req      (w_req_in)
  );

  // confirmed streams waiting for the generator
  pref_ring_fifo #(
    .DEPTH (REQ_DEPTH),
    .T     (stream_req_t)
  ) u_req_fifo (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_push    (w_req_push),
    .i_data    (w_req_in),
    .i_pop     (w_req_pop),
    .o_data    (w_req_out),
    .o_empty   (w_req_empty),
    .o_full    (w_req_full)
  );

  pref_stream_gen u_gen (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_req_empty (w_req_empty),
    .i_req       (w_req_out),
    .o_req_pop   (w_req_pop),
    .o_gen_valid (w_gen_valid),
    .o_gen_vaddr (w_gen_vaddr),
    .i_accept    (w_accept)
  );

  pref_recent_filter u_filter (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_gen_valid  (w_gen_valid),
    .i_gen_vaddr  (w_gen_vaddr),
    .o_accept     (w_accept),
    .i_pref_ready (i_pref_ready),
    .o_pref_valid (o_pref_valid),
    .o_pref_vaddr (o_pref_vaddr)
  );

endmodule

// ==== pref_train_if.sv ====
// training channel from the load monitor to the stride table
interface pref_train_if;
  import pref_cfg_pkg::*;
  import pref_entry_pkg::*;

  logic     valid;  // one cycle per accepted load
  ipt_idx_t idx;    // pc[4:1]
  pc_tag_t  tag;    // pc bits above the index
  vaddr_t   vaddr;  // load data address

  modport mon (
    output valid,
    output idx,
    output tag,
    output vaddr
  );

  modport tbl (
    input valid,
    input idx,
    input tag,
    input vaddr
  );

endinterface

// ==== tb_pref_top.sv ====
// testbench for the stride prefetcher, reference model with in-order scoreboard
module tb_pref_top;
  timeunit 1ns;
  timeprecision 100ps;
  import pref_cfg_pkg::*;
  import pref_entry_pkg::*;

  localparam int N_T1 = 8;   // loads per test
  localparam int N_T2 = 16;
  localparam int N_T3 = 8;
  localparam int N_T4 = 22;
  localparam int N_T5 = 12;  // enough streams to fill the issue FIFO
  localparam int N_T6 = 48;
  localparam int TOTAL_LOADS = N_T1 + N_T2 + N_T3 + N_T4 + N_T5 + N_T6;
  localparam int WATCHDOG_CYCLES = TOTAL_LOADS * 40 + 16;

  logic   i_clk = 1'b0;
  logic   i_reset_n;
  logic   i_ld_valid;
  vaddr_t i_ld_pc;
  vaddr_t i_ld_vaddr;
  logic   i_pref_ready;
  logic   o_pref_valid;
  vaddr_t o_pref_vaddr;

  // ----------------------------------------
  // reference model state
  // ----------------------------------------
  logic                  m_valid [IPT_SIZE];
  pc_tag_t               m_tag [IPT_SIZE];
  logic [PAGE_OFS_W-1:0] m_ofs [IPT_SIZE];
  stride_t               m_stride [IPT_SIZE];
  conf_t                 m_conf [IPT_SIZE];
  logic                  m_last_valid;  // monitor repeat check
  vaddr_t                m_last_pc;
  line_t                 m_last_line;
  line_t                 m_recent [FILTER_SIZE];
  logic                  m_recent_valid [FILTER_SIZE];
  int                    m_rr;
  vaddr_t                exp_q [$];     // expected issue order

  int    seed      = 32'h4c8b26d6;
  int    exp_total = 0;
  int    issued    = 0;
  int    errors    = 0;
  logic  rand_ready = 1'b0;
  string test_name = "reset";

  always #10 i_clk = ~i_clk;

  pref_top UUT (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_ld_valid   (i_ld_valid),
    .i_ld_pc      (i_ld_pc),
    .i_ld_vaddr   (i_ld_vaddr),
    .i_pref_ready (i_pref_ready),
    .o_pref_valid (o_pref_valid),
    .o_pref_vaddr (o_pref_vaddr)
  );

  function automatic void model_reset();
    for (int i = 0; i < IPT_SIZE; i++) begin
      m_valid[i] = 1'b0;
    end
    for (int i = 0; i < FILTER_SIZE; i++) begin
      m_recent_valid[i] = 1'b0;
    end
    m_last_valid = 1'b0;
    m_rr = 0;
  endfunction

  // recent line filter, a miss takes the next round-robin slot
  function automatic void filter_line(vaddr_t a);
    line_t l;
    l = a[VADDR_W-1:LINE_W];
    for (int i = 0; i < FILTER_SIZE; i++) begin
      if (m_recent_valid[i] && m_recent[i] == l) return;
    end
    m_recent[m_rr] = l;
    m_recent_valid[m_rr] = 1'b1;
    m_rr = (m_rr + 1) % FILTER_SIZE;
    exp_q.push_back(a);
    exp_total++;
  endfunction

  function automatic void model_load(vaddr_t pc, vaddr_t va);
    int                    idx;
    pc_tag_t               tag;
    line_t                 line;
    logic [PAGE_OFS_W-1:0] ofs;
    stride_t               st;
    int                    step;
    logic                  match;
    line = va[VADDR_W-1:LINE_W];
    if (m_last_valid && m_last_pc == pc && m_last_line == line) return;
    m_last_valid = 1'b1;
    m_last_pc    = pc;
    m_last_line  = line;
    idx = int'(pc[4:1]);
    tag = pc[13:5];
    ofs = va[PAGE_OFS_W-1:0];
    if (!(m_valid[idx] && m_tag[idx] == tag)) begin
      m_valid[idx]  = 1'b1;  // allocate, start over
      m_tag[idx]    = tag;
      m_ofs[idx]    = ofs;
      m_stride[idx] = '0;
      m_conf[idx]   = '0;
      return;
    end
    st    = ofs - m_ofs[idx];
    match = (st == m_stride[idx]);
    if (match && m_conf[idx] >= 2'd2 && st != '0) begin
      step = int'(st);  // sign extended
      for (int k = 1; k <= NUM_DEGREE; k++) begin
        filter_line(va + vaddr_t'(k * step));
      end
    end
    if (match && m_conf[idx] != 2'd3) m_conf[idx] = m_conf[idx] + 2'd1;
    else if (!match && m_conf[idx] != 2'd0) m_conf[idx] = m_conf[idx] - 2'd1;
    m_ofs[idx]    = ofs;
    m_stride[idx] = st;
  endfunction

  task automatic check_vaddr(input vaddr_t exp, input vaddr_t act);
    if (exp !== act) begin
      errors++;
      $display("ERR %s prefetch address expected %h actual %h", test_name, exp, act);
    end
  endtask

  task automatic check_count(input int exp, input int act);
    if (exp != act) begin
      errors++;
      $display("ERR %s prefetch count expected %0d actual %0d", test_name, exp, act);
    end
  endtask

  // ----------------------------------------
  // scoreboard, one pop per issued prefetch
  // ----------------------------------------
  always @(negedge i_clk) begin
    if (i_reset_n && o_pref_valid) begin
      issued++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("%s: prefetch %h issued but none was expected", test_name, o_pref_vaddr);
      end else begin
        check_vaddr(exp_q.pop_front(), o_pref_vaddr);
      end
    end
  end

  task automatic drive_load(input vaddr_t pc, input vaddr_t va, input int gap);
    @(posedge i_clk);
    #2;
    i_ld_valid = 1'b1;
    i_ld_pc    = pc;
    i_ld_vaddr = va;
    if (rand_ready) i_pref_ready = (($random(seed) & 3) != 0);
    model_load(pc, va);
    repeat (gap) begin
      @(posedge i_clk);
      #2;
      i_ld_valid = 1'b0;
      if (rand_ready) i_pref_ready = (($random(seed) & 3) != 0);
    end
  endtask

  // ready high until the model queue empties, then a margin for extras
  task automatic wait_drain();
    int n;
    n = 0;
    @(posedge i_clk);
    #2;
    rand_ready   = 1'b0;
    i_pref_ready = 1'b1;
    i_ld_valid   = 1'b0;
    while (exp_q.size() != 0 && n < 400) begin
      @(posedge i_clk);
      n++;
    end
    repeat (30) @(posedge i_clk);
  endtask

  // ----------------------------------------
  // tests
  // ----------------------------------------
  task automatic run_steady_stride();
    test_name = "steady_stride";
    for (int i = 0; i < N_T1; i++) begin
      drive_load(32'h0000_1000, 32'h0001_0000 + vaddr_t'(i * 256), 3);
    end
    wait_drain();
  endtask

  task automatic run_neg_and_alternating();
    vaddr_t a;
    test_name = "neg_and_alternating";
    for (int i = 0; i < 8; i++) begin
      drive_load(32'h0000_2004, 32'h0002_8000 - vaddr_t'(i * 192), 3);  // crosses a page
    end
    a = 32'h0003_0400;
    for (int i = 0; i < 8; i++) begin
      drive_load(32'h0000_300a, a, 3);
      a = a + ((i % 2 == 0) ? 32'd128 : 32'd320);
    end
    wait_drain();
  endtask

  task automatic run_index_conflict();
    test_name = "index_conflict";
    for (int i = 0; i < 4; i++) begin
      drive_load(32'h0000_0406, 32'h0004_0000 + vaddr_t'(i * 128), 2);  // same idx 3
      drive_load(32'h0000_0806, 32'h0004_8000 + vaddr_t'(i * 128), 2);
    end
    wait_drain();
  endtask

  task automatic run_overlapping_streams();
    test_name = "overlapping_streams";
    for (int i = 0; i < 8; i++) begin
      drive_load(32'h0000_0110, 32'h0005_0000 + vaddr_t'(i * 64), 2);
      drive_load(32'h0000_0110, 32'h0005_0008 + vaddr_t'(i * 64), 2);  // same line again
    end
    for (int i = 0; i < 6; i++) begin
      drive_load(32'h0000_041a, 32'h0005_0020 + vaddr_t'(i * 64), 2);
    end
    wait_drain();
  endtask

  task automatic run_backpressure();
    test_name = "backpressure";
    @(posedge i_clk);
    #2;
    i_pref_ready = 1'b0;
    for (int i = 0; i < N_T5; i++) begin
      drive_load(32'h0000_0218, 32'h0006_0000 + vaddr_t'(i * 512), 4);
    end
    repeat (80) @(posedge i_clk);
    wait_drain();
  endtask

  task automatic run_random_mix();
    vaddr_t pcs [3];
    vaddr_t addr [3];
    int     strides [3];
    int     j;
    int     gap;
    test_name = "random_mix";
    pcs[0] = 32'h0000_0332;
    pcs[1] = 32'h0000_0354;
    pcs[2] = 32'h0000_0376;
    for (int k = 0; k < 3; k++) begin
      addr[k]    = $random(seed);
      strides[k] = int'(($unsigned($random(seed)) % 4) + 1) * 64;
      if ($random(seed) & 1) strides[k] = -strides[k];
    end
    rand_ready = 1'b1;
    for (int i = 0; i < N_T6; i++) begin
      j   = int'($unsigned($random(seed)) % 3);
      gap = 6 + int'($unsigned($random(seed)) % 4);
      drive_load(pcs[j], addr[j], gap);
      addr[j] = addr[j] + vaddr_t'(strides[j]);
    end
    wait_drain();
  endtask

  initial begin
    i_reset_n    = 1'b0;
    i_ld_valid   = 1'b0;
    i_ld_pc      = '0;
    i_ld_vaddr   = '0;
    i_pref_ready = 1'b1;
    model_reset();
    repeat (16) @(posedge i_clk);
    #2;
    i_reset_n = 1'b1;
    run_steady_stride();
    run_neg_and_alternating();
    run_index_conflict();
    run_overlapping_streams();
    run_backpressure();
    run_random_mix();
    test_name = "final_count";
    check_count(exp_total, issued);
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d expected prefetches were never issued", exp_q.size());
    end
    $display("errors %0d, prefetches issued %0d of %0d", errors, issued, exp_total);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // watchdog, sized from the number of loads
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge i_clk);
    $display("watchdog expired after %0d cycles, run did not complete", WATCHDOG_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule
